// File: src.f
hw/rvPkg.sv
hw/decodeStage.sv
hw/operandStage.sv
hw/executeStage.sv
hw/regFile.sv
hw/integerPipe.sv
verification/pipeChecker.sv
verification/integerPipeTb.sv

// File: Makefile
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check for a pass"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -j 0 --top-module integerPipeTb \
		-f src.f --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/VintegerPipeTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/integerPipeTb.sv
`timescale 1ns/1ns
`default_nettype none

module integerPipeTb
    import rvPkg::*;
();

    localparam int NUM_CYCLES    = 3000;
    localparam int DRAIN_TIMEOUT = 50;

    logic                  clk;
    logic                  rst;
    logic                  instrValid;
    instrU                 instr;
    logic                  retValid;
    logic                  retIllegal;
    logic [REG_ADDR_W-1:0] retRd;
    logic [XLEN-1:0]       retData;
    retirePkt              expected;
    int                    errorCount;
    int                    checkCount;
    int                    pendingCount;

    // Reference state updated at issue
    logic [XLEN-1:0]       modelRegs [REG_COUNT];
    logic [XLEN-1:0]       modelPc;

    integerPipe i_integerPipe (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .retValid   (retValid),
        .retIllegal (retIllegal),
        .retRd      (retRd),
        .retData    (retData)
    );

    pipeChecker i_pipeChecker (
        .clk          (clk),
        .expected     (expected),
        .retValid     (retValid),
        .retIllegal   (retIllegal),
        .retRd        (retRd),
        .retData      (retData),
        .errorCount   (errorCount),
        .checkCount   (checkCount),
        .pendingCount (pendingCount)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // Few registers so dependencies come often
    function automatic logic [4:0] pickReg();
        return 5'($urandom % 5);
    endfunction

    // Base integer ops by funct3
    // Alt selects SUB and SRA
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            // Differing signs decide by the sign of a alone
            3'd2:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            // Arithmetic form refills the vacated upper bits with the sign
            3'd5:    return alt ? ((a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0])))
                                : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Each source extended per its signedness
    // Product taken mod 2^64
    function automatic logic [31:0] mulRef(input logic [2:0] f3, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [63:0] wideA;
        logic [63:0] wideB;
        logic [63:0] prod;
        wideA = (f3 == 3'd1 || f3 == 3'd2) ? {{32{a[31]}}, a} : {32'b0, a};
        wideB = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'b0, b};
        prod  = wideA * wideB;
        return (f3 == 3'd0) ? prod[31:0] : prod[63:32];
    endfunction

    // Weighted mix of legal and illegal encodings
    function automatic logic [31:0] randomInstr();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          pick;
        f3   = 3'($urandom);
        rd   = pickReg();
        rs1  = pickReg();
        rs2  = pickReg();
        imm  = 12'($urandom);
        pick = $urandom % 16;
        f7   = 7'h00;
        if (pick < 5)
        begin
            // SUB and SRA half the time
            if ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1))
            begin
                f7 = 7'h20;
            end
            return {f7, rs2, rs1, f3, rd, OP_REG};
        end
        else if (pick < 8)
        begin
            return {7'h01, rs2, rs1, {1'b0, f3[1:0]}, rd, OP_REG};
        end
        else if (pick < 12)
        begin
            // Shift immediates carry funct7 in the upper bits
            if (f3 == 3'd1)
            begin
                imm[11:5] = 7'h00;
            end
            else if (f3 == 3'd5)
            begin
                imm[11:5] = ($urandom % 2 == 1) ? 7'h20 : 7'h00;
            end
            return {imm, rs1, f3, rd, OP_IMM};
        end
        else if (pick < 14)
        begin
            return {20'($urandom), rd, (pick == 12) ? OP_LUI : OP_AUIPC};
        end
        else
        begin
            pick = $urandom % 4;
            if (pick == 0)
            begin
                return {25'($urandom), 7'b1100011};
            end
            else if (pick == 1)
            begin
                return {imm, rs1, f3, rd, 7'b0000011};
            end
            else if (pick == 2)
            begin
                return {7'h01, rs2, rs1, 3'b100 | f3, rd, OP_REG};
            end
        end
        // Unused funct7 on a register op
        return {7'h40, rs2, rs1, f3, rd, OP_REG};
    endfunction

    // Executes one word by the ISA rules against the model state
    task automatic modelExecute(input logic [31:0] w, output logic ill,
                                output logic [31:0] val);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        f3   = w[14:12];
        f7   = w[31:25];
        a    = modelRegs[w[19:15]];
        b    = modelRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        ill  = 1'b0;
        val  = '0;
        case (w[6:0])
            OP_LUI:   val = {w[31:12], 12'b0};
            OP_AUIPC: val = modelPc + {w[31:12], 12'b0};
            OP_IMM:
            begin
                if ((f3 == 3'd1 && f7 != 7'h00) ||
                    (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))
                begin
                    ill = 1'b1;
                end
                else
                begin
                    val = aluRef(f3, f3 == 3'd5 && f7 == 7'h20, a, immI);
                end
            end
            OP_REG:
            begin
                if (f7 == 7'h00)
                begin
                    val = aluRef(f3, 1'b0, a, b);
                end
                else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
                begin
                    val = aluRef(f3, 1'b1, a, b);
                end
                else if (f7 == 7'h01 && !f3[2])
                begin
                    val = mulRef(f3, a, b);
                end
                else
                begin
                    ill = 1'b1;
                end
            end
            default:  ill = 1'b1;
        endcase
        // x0 never changes
        if (!ill && w[11:7] != 5'd0)
        begin
            modelRegs[w[11:7]] = val;
        end
        modelPc = modelPc + 32'd4;
    endtask

    initial
    begin
        int          seedDummy;
        int          waitCycles;
        logic [31:0] word;
        logic        ill;
        logic [31:0] val;
        seedDummy  = $urandom(95);
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        expected   = '0;
        modelPc    = '0;
        for (int i = 0; i < REG_COUNT; i++)
        begin
            modelRegs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Random gaps between valid words
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
        begin
            @(negedge clk);
            if ($urandom % 4 != 0)
            begin
                word = randomInstr();
                modelExecute(word, ill, val);
                instrValid        = 1'b1;
                instr             = word;
                expected.valid    = 1'b1;
                expected.illegal  = ill;
                expected.rd       = word[11:7];
                expected.writesRd = !ill;
                expected.data     = val;
            end
            else
            begin
                // Garbage on the bus while not valid
                instrValid = 1'b0;
                instr      = $urandom;
                expected   = '0;
            end
        end
        @(negedge clk);
        instrValid = 1'b0;
        expected   = '0;
        waitCycles = 0;
        while (pendingCount != 0 && waitCycles < DRAIN_TIMEOUT)
        begin
            @(posedge clk);
            waitCycles++;
        end
        if (pendingCount != 0)
        begin
            $display("Timed out waiting for the pipeline to drain, %0d retires missing",
                     pendingCount);
        end
        // Catch stray retires after the last one
        repeat (4) @(posedge clk);
        $display("Checked %0d retires, %0d errors, %0d still outstanding",
                 checkCount, errorCount, pendingCount);
        if (errorCount == 0 && pendingCount == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/pipeChecker.sv
`timescale 1ns/1ns
`default_nettype none

module pipeChecker
    import rvPkg::*;
(
    input  wire logic                  clk,
    input  wire retirePkt              expected,
    input  wire logic                  retValid,
    input  wire logic                  retIllegal,
    input  wire logic [REG_ADDR_W-1:0] retRd,
    input  wire logic [XLEN-1:0]       retData,
    output int                         errorCount,
    output int                         checkCount,
    output int                         pendingCount
);

    // Expected records and the edge each one was sampled on
    retirePkt expQ[$];
    int       edgeQ[$];
    int       edgeCount = 0;
    int       pushed = 0;
    int       popped = 0;
    int       errors = 0;

    assign errorCount   = errors;
    assign checkCount   = popped;
    assign pendingCount = pushed - popped;

    // One field against its expected value
    task automatic compareField(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] want);
        if (got !== want)
        begin
            $display("Error: %s got 0x%h, expected 0x%h", name, got, want);
            errors++;
        end
    endtask

    // Same edge the DUT samples the instruction on
    always @(posedge clk)
    begin
        edgeCount = edgeCount + 1;
        if (expected.valid)
        begin
            expQ.push_back(expected);
            edgeQ.push_back(edgeCount);
            pushed++;
        end
    end

    // Retire outputs are settled by the falling edge
    always @(negedge clk)
    begin
        retirePkt want;
        int       issued;
        if (retValid)
        begin
            if (expQ.size() == 0)
            begin
                $display("Error: the DUT retired an instruction that was never issued");
                errors++;
            end
            else
            begin
                want   = expQ.pop_front();
                issued = edgeQ.pop_front();
                popped++;
                // Fixed three-edge latency in issue order
                if (edgeCount - issued != 3)
                begin
                    $display("Error: retire came %0d edges after issue instead of 3",
                             edgeCount - issued);
                    errors++;
                end
                compareField("retIllegal", {31'b0, retIllegal}, {31'b0, want.illegal});
                // Rd and data only mean something for a writing retire
                if (want.writesRd)
                begin
                    compareField("retRd", {27'b0, retRd}, {27'b0, want.rd});
                    compareField("retData", retData, want.data);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/integerPipe.sv
`timescale 1ns/1ns
`default_nettype none

module integerPipe
    import rvPkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             instrValid,
    input  wire instrU            instr,
    output logic                  retValid,
    output logic                  retIllegal,
    output logic [REG_ADDR_W-1:0] retRd,
    output logic [XLEN-1:0]       retData
);

    decodedPkt             dec;
    operandPkt             ops;
    retirePkt              fwdResult;
    retirePkt              ret;
    logic [REG_ADDR_W-1:0] rdAddrA;
    logic [REG_ADDR_W-1:0] rdAddrB;
    logic [XLEN-1:0]       rdDataA;
    logic [XLEN-1:0]       rdDataB;

    decodeStage i_decodeStage (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .dec        (dec)
    );

    // Written from the retire packet one edge after it shows
    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wr      (ret)
    );

    // Forwarding from execute (k-1) and retire (k-2)
    operandStage i_operandStage (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .fwdExec   (fwdResult),
        .fwdRetire (ret),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .ops       (ops)
    );

    executeStage i_executeStage (
        .clk       (clk),
        .rst       (rst),
        .ops       (ops),
        .fwdResult (fwdResult),
        .ret       (ret)
    );

    // Retire ports
    assign retValid   = ret.valid;
    assign retIllegal = ret.illegal;
    assign retRd      = ret.rd;
    assign retData    = ret.data;

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile
    import rvPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [REG_ADDR_W-1:0] rdAddrA,
    input  wire logic [REG_ADDR_W-1:0] rdAddrB,
    output logic      [XLEN-1:0]       rdDataA,
    output logic      [XLEN-1:0]       rdDataB,
    input  wire retirePkt              wr
);

    logic [XLEN-1:0] regs [REG_COUNT];
    logic            wrEn;

    // Retired, legal, writing, and not x0
    assign wrEn = wr.valid && wr.writesRd && !wr.illegal && (wr.rd != '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn)
        begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Combinational reads, x0 hardwired
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage
    import rvPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire operandPkt ops,
    output retirePkt       fwdResult,
    output retirePkt       ret
);

    logic                     signA;
    logic                     signB;
    logic signed [XLEN:0]     mulA;
    logic signed [XLEN:0]     mulB;
    logic signed [2*XLEN+1:0] product;
    logic [4:0]               shamt;
    logic [XLEN-1:0]          result;

    // Shift amount from the low 5 bits of B
    assign shamt = ops.opB[4:0];

    // One 33x33 signed multiplier covers all four variants
    assign signA = (ops.aluOp == MULH) || (ops.aluOp == MULHSU);
    assign signB = (ops.aluOp == MULH);
    // Extend by one bit, sign or zero per operand
    assign mulA = {signA & ops.opA[XLEN-1], ops.opA};
    assign mulB = {signB & ops.opB[XLEN-1], ops.opB};
    assign product = mulA * mulB;

    always_comb
    begin
        case (ops.aluOp)
            ADD:     result = ops.opA + ops.opB;
            SUB:     result = ops.opA - ops.opB;
            SLL:     result = ops.opA << shamt;
            SRL:     result = ops.opA >> shamt;
            SRA:     result = $unsigned($signed(ops.opA) >>> shamt);
            // Compares yield 0 or 1
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(ops.opA) < $signed(ops.opB)};
            SLTU:    result = {{(XLEN-1){1'b0}}, ops.opA < ops.opB};
            XOR:     result = ops.opA ^ ops.opB;
            OR:      result = ops.opA | ops.opB;
            AND:     result = ops.opA & ops.opB;
            // Low word is sign independent
            MUL:     result = product[XLEN-1:0];
            MULH:    result = product[2*XLEN-1:XLEN];
            MULHSU:  result = product[2*XLEN-1:XLEN];
            MULHU:   result = product[2*XLEN-1:XLEN];
            PASSB:   result = ops.opB;
            default: result = '0;
        endcase
    end

    // Unregistered result for forwarding to operand
    always_comb
    begin
        fwdResult.valid    = ops.valid;
        fwdResult.illegal  = ops.illegal;
        fwdResult.rd       = ops.rd;
        fwdResult.writesRd = ops.writesRd;
        fwdResult.data     = result;
    end

    // Retire register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ret <= '0;
        end
        else
        begin
            ret <= fwdResult;
        end
    end

endmodule

`default_nettype wire

// File: hw/operandStage.sv
`timescale 1ns/1ns
`default_nettype none

module operandStage
    import rvPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire decodedPkt             dec,
    input  wire retirePkt              fwdExec,
    input  wire retirePkt              fwdRetire,
    output logic      [REG_ADDR_W-1:0] rdAddrA,
    output logic      [REG_ADDR_W-1:0] rdAddrB,
    input  wire logic [XLEN-1:0]       rdDataA,
    input  wire logic [XLEN-1:0]       rdDataB,
    output operandPkt                  ops
);

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    operandPkt       opsNext;

    // A packet that will write this source register
    function automatic logic hits(input retirePkt p, input logic [REG_ADDR_W-1:0] rs);
        return p.valid && p.writesRd && !p.illegal && (p.rd != '0) && (p.rd == rs);
    endfunction

    // Youngest producer wins: execute, then retire, then the file
    function automatic logic [XLEN-1:0] resolve(input logic [REG_ADDR_W-1:0] rs,
                                                input logic [XLEN-1:0] rfData,
                                                input retirePkt execPkt,
                                                input retirePkt retirePktIn);
        if (hits(execPkt, rs))
        begin
            return execPkt.data;
        end
        if (hits(retirePktIn, rs))
        begin
            return retirePktIn.data;
        end
        return rfData;
    endfunction

    assign rdAddrA = dec.rs1;
    assign rdAddrB = dec.rs2;
    assign srcA = resolve(dec.rs1, rdDataA, fwdExec, fwdRetire);
    assign srcB = resolve(dec.rs2, rdDataB, fwdExec, fwdRetire);

    always_comb
    begin
        opsNext.valid    = dec.valid;
        opsNext.illegal  = dec.illegal;
        opsNext.rd       = dec.rd;
        opsNext.writesRd = dec.writesRd;
        opsNext.aluOp    = dec.aluOp;
        // PC for AUIPC, immediate for I and U forms
        opsNext.opA      = dec.usePc ? dec.pc : srcA;
        opsNext.opB      = dec.useImm ? dec.imm : srcB;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ops <= '0;
        end
        else
        begin
            ops <= opsNext;
        end
    end

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage
    import rvPkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  instrValid,
    input  wire instrU instr,
    output decodedPkt  dec
);

    instrU           word;
    logic            wordValid;
    logic [XLEN-1:0] wordPc;
    logic [XLEN-1:0] pcCount;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immU;
    logic            legal;
    decodedPkt       decNext;

    // funct3 to op for the shared base ALU set
    function automatic aluOpE baseAluOp(input logic [2:0] funct3);
        aluOpE op;
        op = ADD;
        case (funct3)
            F3_ADD:  op = ADD;
            F3_SLL:  op = SLL;
            F3_SLT:  op = SLT;
            F3_SLTU: op = SLTU;
            F3_XOR:  op = XOR;
            F3_SRL:  op = SRL;
            F3_OR:   op = OR;
            F3_AND:  op = AND;
        endcase
        return op;
    endfunction

    // Input word register and program counter
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word      <= '0;
            wordValid <= 1'b0;
            wordPc    <= '0;
            pcCount   <= '0;
        end
        else
        begin
            word      <= instr;
            wordValid <= instrValid;
            // PC of this word, before the step
            wordPc    <= pcCount;
            if (instrValid)
            begin
                pcCount <= pcCount + PC_STEP;
            end
        end
    end

    // I-type sign extended, U-type upper 20 bits
    assign immI = {{(XLEN-12){word.iFormat.imm12[11]}}, word.iFormat.imm12};
    assign immU = {word.rFormat.funct7, word.rFormat.rs2, word.rFormat.rs1,
                   word.rFormat.funct3, 12'b0};

    always_comb
    begin
        legal          = 1'b1;
        decNext.valid  = wordValid;
        decNext.rd     = word.rFormat.rd;
        decNext.rs1    = word.rFormat.rs1;
        decNext.rs2    = word.rFormat.rs2;
        decNext.useImm = 1'b0;
        decNext.usePc  = 1'b0;
        decNext.aluOp  = ADD;
        decNext.imm    = immI;
        decNext.pc     = wordPc;
        case (word.rFormat.opcode)
            OP_LUI:
            begin
                decNext.useImm = 1'b1;
                decNext.aluOp  = PASSB;
                decNext.imm    = immU;
            end
            OP_AUIPC:
            begin
                decNext.useImm = 1'b1;
                decNext.usePc  = 1'b1;
                decNext.imm    = immU;
            end
            OP_IMM:
            begin
                decNext.useImm = 1'b1;
                decNext.aluOp  = baseAluOp(word.iFormat.funct3);
                // Shift immediates reuse the funct7 slot of the R view
                if (word.iFormat.funct3 == F3_SLL)
                begin
                    legal = (word.rFormat.funct7 == F7_BASE);
                end
                else if (word.iFormat.funct3 == F3_SRL)
                begin
                    if (word.rFormat.funct7 == F7_ALT)
                    begin
                        decNext.aluOp = SRA;
                    end
                    else
                    begin
                        legal = (word.rFormat.funct7 == F7_BASE);
                    end
                end
            end
            OP_REG:
            begin
                case (word.rFormat.funct7)
                    F7_BASE: decNext.aluOp = baseAluOp(word.rFormat.funct3);
                    F7_ALT:
                    begin
                        case (word.rFormat.funct3)
                            F3_ADD:  decNext.aluOp = SUB;
                            F3_SRL:  decNext.aluOp = SRA;
                            default: legal = 1'b0;
                        endcase
                    end
                    F7_MULDIV:
                    begin
                        case (word.rFormat.funct3)
                            F3_MUL:    decNext.aluOp = MUL;
                            F3_MULH:   decNext.aluOp = MULH;
                            F3_MULHSU: decNext.aluOp = MULHSU;
                            F3_MULHU:  decNext.aluOp = MULHU;
                            // Divide and remainder not supported
                            default:   legal = 1'b0;
                        endcase
                    end
                    default: legal = 1'b0;
                endcase
            end
            // Loads, stores, branches, jumps, fence, system
            default: legal = 1'b0;
        endcase
        // Only a valid word can be illegal or write
        decNext.illegal  = wordValid && !legal;
        decNext.writesRd = wordValid && legal;
    end

    // Decoded packet register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dec <= '0;
        end
        else
        begin
            dec <= decNext;
        end
    end

endmodule

`default_nettype wire

// File: hw/rvPkg.sv
`default_nettype none

package rvPkg;

    // Fixed by the RV32 ISA
    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_ADDR_W = 5;
    // PC advance per 32-bit word
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // Major opcodes handled by the core
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;

    // funct7 groups
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    // SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // funct3 of the base ALU ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of the multiply group, 1xx is divide/remainder
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    // ALU operations
    typedef enum logic [4:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU,
        // Operand B straight through, for LUI
        PASSB
    } aluOpE;

    // R-type field layout
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } rFormatS;

    // I-type field layout
    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } iFormatS;

    // One instruction word, two views
    typedef union packed {
        rFormatS rFormat;
        iFormatS iFormat;
    } instrU;

    // Decode to operand
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  useImm;
        // AUIPC takes the PC as operand A
        logic                  usePc;
        logic                  writesRd;
        aluOpE                 aluOp;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
    } decodedPkt;

    // Operand to execute
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic                  writesRd;
        aluOpE                 aluOp;
        logic [XLEN-1:0]       opA;
        logic [XLEN-1:0]       opB;
    } operandPkt;

    // Execute to register file and ports
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic                  writesRd;
        logic [XLEN-1:0]       data;
    } retirePkt;

endpackage

`default_nettype wire
